// ==== hdl/perf_bench_ctrl_parser.sv ====
`timescale 1ns/1ps
`include "perf_bench_defs.svh"

module perf_bench_ctrl_parser (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  perf_bench_pkg::axil_addr_t         s_axil_awaddr,
  input  logic                               s_axil_awvalid,
  output logic                               s_axil_awready,
  input  perf_bench_pkg::axil_data_t         s_axil_wdata,
  input  logic [`PB_AXIL_DATA_BITS/8-1:0]    s_axil_wstrb,
  input  logic                               s_axil_wvalid,
  output logic                               s_axil_wready,
  output logic [1:0]                         s_axil_bresp,
  output logic                               s_axil_bvalid,
  input  logic                               s_axil_bready,
  input  perf_bench_pkg::axil_addr_t         s_axil_araddr,
  input  logic                               s_axil_arvalid,
  output logic                               s_axil_arready,
  output perf_bench_pkg::axil_data_t         s_axil_rdata,
  output logic [1:0]                         s_axil_rresp,
  output logic                               s_axil_rvalid,
  input  logic                               s_axil_rready,
  input  perf_bench_pkg::rep_cnt_t           bench_done,
  input  perf_bench_pkg::cycle_cnt_t         bench_timer,
  output logic                               bench_start,
  output perf_bench_pkg::bench_op_t          bench_op,
  output perf_bench_pkg::vaddr_t             bench_vaddr,
  output perf_bench_pkg::len_t               bench_len,
  output perf_bench_pkg::pid_t               bench_pid,
  output perf_bench_pkg::rep_cnt_t           bench_n_reps,
  output perf_bench_pkg::beat_cnt_t          bench_n_beats
);

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  localparam int N_REGS    = 8;
  localparam int STRB_BITS = `PB_AXIL_DATA_BITS / 8;
  localparam int ADDR_LSB  = $clog2(STRB_BITS);

  perf_bench_pkg::axil_addr_t awaddr_q;
  perf_bench_pkg::axil_addr_t araddr_q;
  logic [`PB_AXIL_ADDR_BITS-ADDR_LSB-1:0] wr_idx;
  logic [`PB_AXIL_ADDR_BITS-ADDR_LSB-1:0] rd_idx;
  logic aw_en;
  logic wr_en;
  logic rd_en;
  logic wr_ok;

  // Register file, DONE and TIMER slots stay zero
  perf_bench_pkg::axil_data_t ctrl_reg [N_REGS];

  // Word index from byte address
  assign wr_idx = awaddr_q[`PB_AXIL_ADDR_BITS-1:ADDR_LSB];
  assign rd_idx = araddr_q[`PB_AXIL_ADDR_BITS-1:ADDR_LSB];

  assign wr_en = s_axil_awready && s_axil_awvalid && s_axil_wready && s_axil_wvalid;
  assign rd_en = s_axil_arready && s_axil_arvalid && !s_axil_rvalid;
  // Status registers are read only
  assign wr_ok = (wr_idx != `PB_REG_DONE) && (wr_idx != `PB_REG_TIMER);

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int r = 0; r < N_REGS; r++) begin
        ctrl_reg[r] <= '0;
      end
    end else begin
      // CTRL is one-shot, cleared unless written this edge
      ctrl_reg[`PB_REG_CTRL] <= '0;
      if (wr_en && wr_ok) begin
        for (int i = 0; i < STRB_BITS; i++) begin
          // Byte lanes under strobe only
          if (s_axil_wstrb[i]) begin
            ctrl_reg[wr_idx][i*8 +: 8] <= s_axil_wdata[i*8 +: 8];
          end
        end
      end
    end
  end

  // Settings out
  assign bench_op      = ctrl_reg[`PB_REG_CTRL][1:0];
  assign bench_vaddr   = perf_bench_pkg::vaddr_t'(ctrl_reg[`PB_REG_VADDR]);
  assign bench_len     = perf_bench_pkg::len_t'(ctrl_reg[`PB_REG_LEN]);
  assign bench_pid     = perf_bench_pkg::pid_t'(ctrl_reg[`PB_REG_PID]);
  assign bench_n_reps  = perf_bench_pkg::rep_cnt_t'(ctrl_reg[`PB_REG_N_REPS]);
  assign bench_n_beats = perf_bench_pkg::beat_cnt_t'(ctrl_reg[`PB_REG_N_BEATS]);

  // Only read and write codes start a run
  assign bench_start = (bench_op == `PB_OP_READ) || (bench_op == `PB_OP_WRITE);

  //////////////////////////////////////////////////////////////////////
  // Write channel handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      aw_en          <= 1'b1;
      awaddr_q       <= '0;
    end else begin
      // Address and data taken together, one write in flight
      if (!s_axil_awready && s_axil_awvalid && s_axil_wvalid && aw_en) begin
        s_axil_awready <= 1'b1;
        s_axil_wready  <= 1'b1;
        aw_en          <= 1'b0;
        awaddr_q       <= s_axil_awaddr;
      end else begin
        s_axil_awready <= 1'b0;
        s_axil_wready  <= 1'b0;
        // Reopen after the response is taken
        if (s_axil_bready && s_axil_bvalid) begin
          aw_en <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_bvalid <= 1'b0;
    end else if (wr_en && !s_axil_bvalid) begin
      s_axil_bvalid <= 1'b1;
    end else if (s_axil_bready && s_axil_bvalid) begin
      s_axil_bvalid <= 1'b0;
    end
  end

  // Always OKAY
  assign s_axil_bresp = 2'b00;
  assign s_axil_rresp = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // Read channel handshake and data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_arready <= 1'b0;
      araddr_q       <= '0;
    end else if (!s_axil_arready && s_axil_arvalid && !s_axil_rvalid) begin
      s_axil_arready <= 1'b1;
      araddr_q       <= s_axil_araddr;
    end else begin
      s_axil_arready <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_rvalid <= 1'b0;
      s_axil_rdata  <= '0;
    end else if (rd_en) begin
      s_axil_rvalid <= 1'b1;
      // Status only, settings read back as zero
      case (rd_idx)
        `PB_REG_DONE:  s_axil_rdata <= perf_bench_pkg::axil_data_t'(bench_done);
        `PB_REG_TIMER: s_axil_rdata <= perf_bench_pkg::axil_data_t'(bench_timer);
        default:       s_axil_rdata <= '0;
      endcase
    end else if (s_axil_rvalid && s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  // Responses held until the host takes them
  assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);
  assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid);

endmodule

// ==== hdl/perf_bench_defs.svh ====
`ifndef PERF_BENCH_DEFS_SVH
`define PERF_BENCH_DEFS_SVH

// AXI-Lite bus widths
`define PB_AXIL_DATA_BITS 64
`define PB_AXIL_ADDR_BITS 6

// Benchmark setting widths
`define PB_VADDR_BITS 48
`define PB_LEN_BITS   28
`define PB_PID_BITS   6

// Register indices, 8-byte spacing
`define PB_REG_CTRL    3'd0
`define PB_REG_DONE    3'd1
`define PB_REG_TIMER   3'd2
`define PB_REG_VADDR   3'd3
`define PB_REG_LEN     3'd4
`define PB_REG_PID     3'd5
`define PB_REG_N_REPS  3'd6
`define PB_REG_N_BEATS 3'd7

// Start codes in CTRL
`define PB_OP_READ  2'd1
`define PB_OP_WRITE 2'd2

`endif

// ==== hdl/perf_bench_engine.sv ====
`timescale 1ns/1ps

module perf_bench_engine (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic                        bench_start,
  input  perf_bench_pkg::bench_op_t   bench_op,
  input  perf_bench_pkg::vaddr_t      bench_vaddr,
  input  perf_bench_pkg::len_t        bench_len,
  input  perf_bench_pkg::pid_t        bench_pid,
  input  perf_bench_pkg::rep_cnt_t    bench_n_reps,
  input  perf_bench_pkg::beat_cnt_t   bench_n_beats,
  input  logic                        beat_strobe,
  output logic                        req_strobe,
  output perf_bench_pkg::bench_op_t   req_op,
  output perf_bench_pkg::vaddr_t      req_vaddr,
  output perf_bench_pkg::len_t        req_len,
  output perf_bench_pkg::pid_t        req_pid,
  output logic                        run_start,
  output logic                        rep_done,
  output logic                        busy
);

  perf_bench_pkg::engine_state_t state;
  perf_bench_pkg::engine_state_t state_nxt;
  perf_bench_pkg::rep_cnt_t      rep_idx;
  perf_bench_pkg::rep_cnt_t      n_reps_q;
  perf_bench_pkg::beat_cnt_t     beat_cnt;
  perf_bench_pkg::beat_cnt_t     n_beats_q;
  logic                          last_rep;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  // Starts seen only in IDLE, so a start while busy is dropped
  assign run_start = (state == perf_bench_pkg::IDLE) && bench_start;
  // Beat that completes the repetition
  assign rep_done  = (state == perf_bench_pkg::COLLECT) && beat_strobe &&
                     (beat_cnt + 64'd1 >= n_beats_q);
  assign last_rep  = (rep_idx + 32'd1 >= n_reps_q);
  assign busy      = (state != perf_bench_pkg::IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      perf_bench_pkg::IDLE: begin
        // Zero reps: run_start only, no request
        if (bench_start && (bench_n_reps != '0)) begin
          state_nxt = perf_bench_pkg::ISSUE;
        end
      end
      perf_bench_pkg::ISSUE: begin
        state_nxt = perf_bench_pkg::COLLECT;
      end
      perf_bench_pkg::COLLECT: begin
        if (rep_done) begin
          state_nxt = last_rep ? perf_bench_pkg::IDLE : perf_bench_pkg::ISSUE;
        end
      end
      default: state_nxt = perf_bench_pkg::IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= perf_bench_pkg::IDLE;
      req_strobe <= 1'b0;
      rep_idx    <= '0;
      beat_cnt   <= '0;
    end else begin
      state      <= state_nxt;
      // Strobe lines up with the single ISSUE cycle
      req_strobe <= (state_nxt == perf_bench_pkg::ISSUE);
      if (run_start) begin
        rep_idx <= '0;
      end else if (rep_done) begin
        rep_idx <= rep_idx + 32'd1;
      end
      // Fresh beat count per request
      if (state == perf_bench_pkg::ISSUE) begin
        beat_cnt <= '0;
      end else if ((state == perf_bench_pkg::COLLECT) && beat_strobe) begin
        beat_cnt <= beat_cnt + 64'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (run_start) begin
      req_op    <= bench_op;
      req_vaddr <= bench_vaddr;
      req_len   <= bench_len;
      req_pid   <= bench_pid;
      n_reps_q  <= bench_n_reps;
      n_beats_q <= bench_n_beats;
    end else if (rep_done) begin
      // Next buffer slice
      req_vaddr <= req_vaddr + perf_bench_pkg::vaddr_t'(req_len);
    end
  end

  // Each request follows an accepted start or a finished repetition
  assert property (@(posedge aclk) disable iff (!aresetn)
    req_strobe |-> $past(run_start || rep_done));
  assert property (@(posedge aclk) disable iff (!aresetn)
    !(req_strobe && rep_done));

endmodule

// ==== hdl/perf_bench_pkg.sv ====
`include "perf_bench_defs.svh"

package perf_bench_pkg;

  // AXI-Lite words and addresses
  typedef logic [`PB_AXIL_DATA_BITS-1:0] axil_data_t;
  typedef logic [`PB_AXIL_ADDR_BITS-1:0] axil_addr_t;

  // Buffer settings
  typedef logic [`PB_VADDR_BITS-1:0] vaddr_t;
  typedef logic [`PB_LEN_BITS-1:0]   len_t;
  typedef logic [`PB_PID_BITS-1:0]   pid_t;

  // Counters
  typedef logic [31:0] rep_cnt_t;
  typedef logic [63:0] beat_cnt_t;
  typedef logic [63:0] cycle_cnt_t;

  // Read or write code
  typedef logic [1:0] bench_op_t;

  // Engine FSM
  typedef enum logic [1:0] {IDLE, ISSUE, COLLECT} engine_state_t;

endpackage

// ==== hdl/perf_bench_stats.sv ====
`timescale 1ns/1ps

module perf_bench_stats (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         run_start,
  input  logic                         rep_done,
  input  logic                         busy,
  output perf_bench_pkg::rep_cnt_t     bench_done,
  output perf_bench_pkg::cycle_cnt_t   bench_timer
);

  //////////////////////////////////////////////////////////////////////
  // Completions and run time
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bench_done  <= '0;
      bench_timer <= '0;
    end else if (run_start) begin
      // New run, previous result dropped
      bench_done  <= '0;
      bench_timer <= '0;
    end else begin
      if (rep_done) begin
        bench_done <= bench_done + 32'd1;
      end
      // Counts busy cycles only, holds afterwards
      if (busy) begin
        bench_timer <= bench_timer + 64'd1;
      end
    end
  end

  // Engine completes reps only inside a run
  assert property (@(posedge aclk) disable iff (!aresetn)
    rep_done |-> busy);

endmodule

// ==== hdl/perf_bench_top.sv ====
`timescale 1ns/1ps
`include "perf_bench_defs.svh"

module perf_bench_top (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  perf_bench_pkg::axil_addr_t         s_axil_awaddr,
  input  logic                               s_axil_awvalid,
  output logic                               s_axil_awready,
  input  perf_bench_pkg::axil_data_t         s_axil_wdata,
  input  logic [`PB_AXIL_DATA_BITS/8-1:0]    s_axil_wstrb,
  input  logic                               s_axil_wvalid,
  output logic                               s_axil_wready,
  output logic [1:0]                         s_axil_bresp,
  output logic                               s_axil_bvalid,
  input  logic                               s_axil_bready,
  input  perf_bench_pkg::axil_addr_t         s_axil_araddr,
  input  logic                               s_axil_arvalid,
  output logic                               s_axil_arready,
  output perf_bench_pkg::axil_data_t         s_axil_rdata,
  output logic [1:0]                         s_axil_rresp,
  output logic                               s_axil_rvalid,
  input  logic                               s_axil_rready,
  output logic                               req_strobe,
  output perf_bench_pkg::bench_op_t          req_op,
  output perf_bench_pkg::vaddr_t             req_vaddr,
  output perf_bench_pkg::len_t               req_len,
  output perf_bench_pkg::pid_t               req_pid,
  input  logic                               beat_strobe
);

  // Parser to engine
  logic                         bench_start;
  perf_bench_pkg::bench_op_t    bench_op;
  perf_bench_pkg::vaddr_t       bench_vaddr;
  perf_bench_pkg::len_t         bench_len;
  perf_bench_pkg::pid_t         bench_pid;
  perf_bench_pkg::rep_cnt_t     bench_n_reps;
  perf_bench_pkg::beat_cnt_t    bench_n_beats;

  // Engine to stats
  logic                         run_start;
  logic                         rep_done;
  logic                         busy;

  // Stats back to the host
  perf_bench_pkg::rep_cnt_t     bench_done;
  perf_bench_pkg::cycle_cnt_t   bench_timer;

  // Port names match across blocks
  perf_bench_ctrl_parser u_ctrl_parser (.*);

  perf_bench_engine u_engine (.*);

  perf_bench_stats u_stats (.*);

endmodule

// ==== perf_bench.f ====
+incdir+hdl
hdl/perf_bench_pkg.sv
hdl/perf_bench_ctrl_parser.sv
hdl/perf_bench_engine.sv
hdl/perf_bench_stats.sv
hdl/perf_bench_top.sv
tb/tb_perf_bench.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_perf_bench -f perf_bench.f -o tb_perf_bench \
  && ./obj_dir/tb_perf_bench > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -qs "all tests passed" sim.log && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// ==== tb/perf_bench_vectors.txt ====
# name op vaddr len pid n_reps n_beats gap start_while_busy
# hex: op vaddr len pid, then decimal: n_reps n_beats gap flag
read_basic    1 000000001000 0000040 03 4  4  0 0
write_basic   2 00007fff0000 0000100 1f 3  8  1 0
read_single   1 0000deadbe00 0000020 01 1  1  0 0
zero_reps     1 000000002000 0000040 02 0  4  0 0
code_zero     0 000000003000 0000040 04 2  2  0 0
code_three    3 000000004000 0000040 05 2  2  0 0
busy_restart  1 000012340000 0000080 2a 6  6  1 1
write_gap     2 0000fffff000 0001000 3f 5  3  4 0
read_wrap     1 ffffffffffc0 0000040 07 4  2  0 0
write_busy    2 000100000000 0fffff8 10 4  5  2 1
long_burst    1 000000800000 00000c0 11 3 16  0 0

// ==== tb/tb_perf_bench.sv ====
`timescale 1ns/1ps
`include "perf_bench_defs.svh"

module tb_perf_bench;

  localparam int MAX_TESTS = 32;

  logic                               aclk;
  logic                               aresetn;
  perf_bench_pkg::axil_addr_t         s_axil_awaddr;
  logic                               s_axil_awvalid;
  logic                               s_axil_awready;
  perf_bench_pkg::axil_data_t         s_axil_wdata;
  logic [`PB_AXIL_DATA_BITS/8-1:0]    s_axil_wstrb;
  logic                               s_axil_wvalid;
  logic                               s_axil_wready;
  logic [1:0]                         s_axil_bresp;
  logic                               s_axil_bvalid;
  logic                               s_axil_bready;
  perf_bench_pkg::axil_addr_t         s_axil_araddr;
  logic                               s_axil_arvalid;
  logic                               s_axil_arready;
  perf_bench_pkg::axil_data_t         s_axil_rdata;
  logic [1:0]                         s_axil_rresp;
  logic                               s_axil_rvalid;
  logic                               s_axil_rready;
  logic                               req_strobe;
  perf_bench_pkg::bench_op_t          req_op;
  perf_bench_pkg::vaddr_t             req_vaddr;
  perf_bench_pkg::len_t               req_len;
  perf_bench_pkg::pid_t               req_pid;
  logic                               beat_strobe;

  // Vector table, one row per run
  logic [191:0] t_name  [MAX_TESTS];
  logic [63:0]  t_op    [MAX_TESTS];
  logic [63:0]  t_vaddr [MAX_TESTS];
  logic [63:0]  t_len   [MAX_TESTS];
  logic [63:0]  t_pid   [MAX_TESTS];
  int           t_reps  [MAX_TESTS];
  int           t_beats [MAX_TESTS];
  int           t_gap   [MAX_TESTS];
  int           t_busy  [MAX_TESTS];
  int           n_tests;

  // Current run, shared with the memory responder
  string        cur_name;
  logic [63:0]  exp_op;
  logic [63:0]  exp_vaddr;
  logic [63:0]  exp_len;
  logic [63:0]  exp_pid;
  int           cur_beats;
  int           cur_gap;
  logic [63:0]  req_count;
  logic [63:0]  run_base;
  logic [31:0]  lcg_state;
  logic [63:0]  last_done;
  logic [63:0]  last_timer;
  int           cycle_count = 0;
  int           cycle_limit = 0;

  perf_bench_top UUT (.*);

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Gap before a beat, at least one cycle plus 0..3 random
  function automatic int beat_wait(input int gap, input logic [31:0] rnd);
    return gap + int'(rnd[17:16]) + 1;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual == expected) else begin
      $display("[FAIL] %s: %s expected %0h actual %0h", test, what, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // Address and data together, bready held high
  task automatic axil_write(input logic [2:0] idx, input logic [63:0] data,
                            input logic [7:0] strb);
    @(posedge aclk);
    #2;
    s_axil_awaddr  = {idx, 3'b000};
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_wvalid  = 1'b1;
    do begin
      @(posedge aclk);
      #2;
    end while (!s_axil_awready);
    // Handshake on the next edge
    @(posedge aclk);
    #2;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid) begin
      @(posedge aclk);
      #2;
    end
    // Slave answers OKAY only
    check_value(cur_name, "BRESP", 64'd0, {62'd0, s_axil_bresp});
  endtask

  task automatic axil_read(input logic [2:0] idx, output logic [63:0] data);
    @(posedge aclk);
    #2;
    s_axil_araddr  = {idx, 3'b000};
    s_axil_arvalid = 1'b1;
    do begin
      @(posedge aclk);
      #2;
    end while (!s_axil_arready);
    @(posedge aclk);
    #2;
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) begin
      @(posedge aclk);
      #2;
    end
    data = s_axil_rdata;
    check_value(cur_name, "RRESP", 64'd0, {62'd0, s_axil_rresp});
  endtask

  task automatic load_vectors();
    int          fd;
    string       line;
    logic [191:0] f_name;
    logic [63:0] f_op;
    logic [63:0] f_vaddr;
    logic [63:0] f_len;
    logic [63:0] f_pid;
    int          f_reps;
    int          f_beats;
    int          f_gap;
    int          f_busy;
    fd = $fopen("tb/perf_bench_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tb/perf_bench_vectors.txt");
      $display("tests failed");
      $fatal(1);
    end
    n_tests = 0;
    while (!$feof(fd) && (n_tests < MAX_TESTS)) begin
      if ($fgets(line, fd) != 0) begin
        // Comment and blank lines do not give nine fields
        if ($sscanf(line, "%s %h %h %h %h %d %d %d %d", f_name, f_op, f_vaddr, f_len,
                    f_pid, f_reps, f_beats, f_gap, f_busy) == 9) begin
          t_name[n_tests]  = f_name;
          t_op[n_tests]    = f_op;
          t_vaddr[n_tests] = f_vaddr;
          t_len[n_tests]   = f_len;
          t_pid[n_tests]   = f_pid;
          t_reps[n_tests]  = f_reps;
          t_beats[n_tests] = f_beats;
          t_gap[n_tests]   = f_gap;
          t_busy[n_tests]  = f_busy;
          n_tests = n_tests + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One benchmark run
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int i);
    logic        starts;
    logic [63:0] rd;
    logic [63:0] timer_a;
    logic [63:0] timer_b;
    logic [63:0] min_cycles;
    logic [63:0] exp_done;
    logic [63:0] exp_timer;
    cur_name  = $sformatf("%0s", t_name[i]);
    exp_op    = t_op[i];
    exp_vaddr = t_vaddr[i];
    exp_len   = t_len[i];
    exp_pid   = t_pid[i];
    cur_beats = t_beats[i];
    cur_gap   = t_gap[i];
    run_base  = req_count;
    starts    = (t_op[i][1:0] == `PB_OP_READ) || (t_op[i][1:0] == `PB_OP_WRITE);
    axil_write(`PB_REG_VADDR, t_vaddr[i], 8'hff);
    // Low byte of LEN first holds junk, then only that lane is rewritten
    axil_write(`PB_REG_LEN, {t_len[i][63:8], 8'ha5}, 8'hff);
    axil_write(`PB_REG_LEN, {56'hff_ffff_ffff_ffff, t_len[i][7:0]}, 8'h01);
    axil_write(`PB_REG_PID, t_pid[i], 8'hff);
    axil_write(`PB_REG_N_REPS, 64'(t_reps[i]), 8'hff);
    axil_write(`PB_REG_N_BEATS, 64'(t_beats[i]), 8'hff);
    axil_write(`PB_REG_CTRL, t_op[i], 8'hff);
    // Start pulse after the write edge, engine busy one edge later
    @(posedge aclk);
    #2;
    check_value(cur_name, "busy after start", {63'd0, starts && (t_reps[i] != 0)},
                {63'd0, UUT.busy});
    if (t_busy[i] != 0) begin
      // Second start with other settings lands mid-run
      axil_write(`PB_REG_N_REPS, 64'(t_reps[i] + 3), 8'hff);
      axil_write(`PB_REG_CTRL, t_op[i], 8'hff);
      check_value(cur_name, "busy during restart", 64'd1, {63'd0, UUT.busy});
    end
    while (UUT.busy) begin
      @(posedge aclk);
      #2;
    end
    check_value(cur_name, "request count", starts ? 64'(t_reps[i]) : 64'd0,
                req_count - run_base);
    // DONE holds the previous result when nothing started
    exp_done = starts ? 64'(t_reps[i]) : last_done;
    axil_read(`PB_REG_DONE, rd);
    check_value(cur_name, "DONE", exp_done, rd);
    last_done = exp_done;
    min_cycles = 64'(t_reps[i]) * 64'(t_beats[i]);
    axil_read(`PB_REG_TIMER, timer_a);
    if (!starts || (t_reps[i] == 0)) begin
      // Held count when nothing started, cleared count for zero reps
      exp_timer = starts ? 64'd0 : last_timer;
      check_value(cur_name, "TIMER", exp_timer, timer_a);
    end else begin
      assert (timer_a >= min_cycles) else begin
        $display("[FAIL] %s: TIMER expected at least %0d actual %0d", cur_name, min_cycles,
                 timer_a);
        $display("tests failed");
        $fatal(1);
      end
    end
    repeat (6) @(posedge aclk);
    axil_read(`PB_REG_TIMER, timer_b);
    check_value(cur_name, "TIMER hold", timer_a, timer_b);
    last_timer = timer_b;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////////////////////////

  initial begin : responder
    int          beats_left;
    int          wait_left;
    logic [63:0] rep_idx;
    logic [47:0] addr_exp;
    lcg_state   = 32'hdda6;
    beat_strobe = 1'b0;
    req_count   = '0;
    beats_left  = 0;
    wait_left   = 0;
    forever begin
      @(posedge aclk);
      #2;
      beat_strobe = 1'b0;
      if (req_strobe) begin
        // Slice address from start, index and length
        rep_idx  = req_count - run_base;
        addr_exp = exp_vaddr[47:0] + rep_idx[47:0] * exp_len[47:0];
        check_value(cur_name, "req_op", exp_op, {62'd0, req_op});
        check_value(cur_name, "req_pid", exp_pid, {58'd0, req_pid});
        check_value(cur_name, "req_len", exp_len, {36'd0, req_len});
        check_value(cur_name, "req_vaddr", {16'd0, addr_exp}, {16'd0, req_vaddr});
        req_count  = req_count + 64'd1;
        beats_left = cur_beats;
        lcg_state  = lcg_next(lcg_state);
        wait_left  = beat_wait(cur_gap, lcg_state);
      end else if (beats_left > 0) begin
        wait_left = wait_left - 1;
        if (wait_left == 0) begin
          beat_strobe = 1'b1;
          beats_left  = beats_left - 1;
          lcg_state   = lcg_next(lcg_state);
          wait_left   = beat_wait(cur_gap, lcg_state);
        end
      end
    end
  end

  // Watchdog
  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("run exceeded its cycle limit");
      $display("tests failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [63:0] rd;
    int          limit;
    aresetn        = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    last_done      = '0;
    last_timer     = '0;
    load_vectors();
    if (n_tests == 0) begin
      $display("no test vectors were read");
      $display("tests failed");
      $fatal(1);
    end
    // Worst case per beat is gap plus 4 cycles
    limit = 0;
    for (int i = 0; i < n_tests; i++) begin
      limit = limit + t_reps[i] * t_beats[i] * (t_gap[i] + 4) + 200;
    end
    cycle_limit = limit;
    repeat (4) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    // Status after reset, settings read back as zero
    cur_name = "reset_state";
    axil_read(`PB_REG_DONE, rd);
    check_value(cur_name, "DONE", 64'd0, rd);
    axil_read(`PB_REG_TIMER, rd);
    check_value(cur_name, "TIMER", 64'd0, rd);
    axil_write(`PB_REG_VADDR, 64'h0000_1234_5678_9abc, 8'hff);
    axil_read(`PB_REG_VADDR, rd);
    check_value(cur_name, "VADDR readback", 64'd0, rd);
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule
